//--- rtl/dds_cfg.svh
// ********************
// size macros for the parallel DDS
// ********************
`ifndef DDS_CFG_SVH
`define DDS_CFG_SVH

// width of the phase accumulator, one full turn of the cosine
// is 2**DDS_PHASE_BITS counts
`define DDS_PHASE_BITS 24

// width of one signed output sample
`define DDS_SAMPLE_BITS 18

// address width of the quarter-wave table
// the two bits above it select the quadrant
`define DDS_LUT_ADDR_BITS 10

// number of table entries, one quadrant of the wave
`define DDS_LUT_DEPTH (1 << `DDS_LUT_ADDR_BITS)

// consecutive samples carried by one output beat
`define DDS_LANES 4

// register stages from the phase register to the output register:
// phase register, lane fold, table read and output register
`define DDS_PIPE_DEPTH 4

`endif

//--- rtl/dds_pkg.sv
// ********************
// DDS data types: phase, sample, lane phases, output beat
// ********************
`include "dds_cfg.svh"

package dds_pkg;

  // unsigned phase word, wraps modulo 2**DDS_PHASE_BITS
  typedef logic [`DDS_PHASE_BITS-1:0] phase_t;

  // signed two's complement cosine sample
  typedef logic signed [`DDS_SAMPLE_BITS-1:0] sample_t;

  // one phase per lane, all taken from the same base phase
  // element k is base + k * increment
  typedef struct packed {
    phase_t [`DDS_LANES-1:0] phase;
  } lane_phases_t;

  // one beat of the output stream
  // element 0 sits in the low bits and is the earliest sample in time
  typedef struct packed {
    sample_t [`DDS_LANES-1:0] sample;
  } cos_beat_t;

endpackage

//--- rtl/dds_phase_gen.sv
// ********************
// increment register, phase accumulator, lane phases
// ********************
`timescale 1ns/1ps
`include "dds_cfg.svh"

module dds_phase_gen
  import dds_pkg::*;
(
  input  logic         clk,
  input  logic         reset,
  input  logic         advance,
  input  logic         phase_inc_valid,
  input  phase_t       phase_inc,
  output lane_phases_t lane_phases
);

  // current increment per sample
  phase_t inc_q;
  // increment per beat, DDS_LANES times inc_q
  phase_t stride_q;
  // phase of lane 0 in the next word to be loaded
  phase_t base_q;
  // offset of each lane from the base phase
  phase_t lane_offset [`DDS_LANES];

  // the increment and the stride both load from the input port on the
  // strobe edge, so the first advance after that edge already sees the
  // new stride together with the new lane offsets
  // a strobe wins over reset, this lets the increment be set up while
  // the rest of the design is still held in reset
  always_ff @(posedge clk) begin
    if (phase_inc_valid) begin
      inc_q    <= phase_inc;
      stride_q <= phase_t'(phase_inc * `DDS_LANES);
    end else if (reset) begin
      inc_q    <= '0;
      stride_q <= '0;
    end
  end

  // lane k sits k increments after lane 0
  // the products are constant multiples of inc_q and wrap like the phase
  always_comb begin
    for (int k = 0; k < `DDS_LANES; k++) begin
      lane_offset[k] = phase_t'(inc_q * k);
    end
  end

  // the base phase moves on by one beat worth of samples per advance
  // and wraps naturally at the width of phase_t
  always_ff @(posedge clk) begin
    if (reset) begin
      base_q <= '0;
    end else if (advance) begin
      base_q <= base_q + stride_q;
    end
  end

  // phase register, the first stage of the pipeline
  // it captures the base before the accumulator steps, so the first word
  // after reset starts at phase 0
  always_ff @(posedge clk) begin
    if (advance) begin
      for (int k = 0; k < `DDS_LANES; k++) begin
        lane_phases.phase[k] <= base_q + lane_offset[k];
      end
    end
  end

endmodule

//--- rtl/dds_quarter_lut.sv
// ********************
// quarter-wave cosine ROM with registered read
// ********************
`timescale 1ns/1ps
`include "dds_cfg.svh"

module dds_quarter_lut
  import dds_pkg::*;
(
  input  logic                          clk,
  input  logic                          advance,
  input  logic [`DDS_LUT_ADDR_BITS-1:0] addr,
  output sample_t                       magnitude
);

  localparam int  DEPTH = `DDS_LUT_DEPTH;
  localparam real PI    = 3.14159265358979;
  // peak amplitude, half a count below full scale so that the largest
  // entry still fits the positive range of sample_t
  localparam real AMPL  = (2.0 ** (`DDS_SAMPLE_BITS - 1)) - 0.5;

  // one quadrant of the cosine, all entries are positive
  sample_t rom [DEPTH];

  // address a stands for the angle (a + 0.5) steps into the quadrant
  // with that half step the mirrored address ~a lands on exactly the
  // reflected angle, so the second and fourth quadrants need no extra entry
  initial begin
    real theta;
    for (int a = 0; a < DEPTH; a++) begin
      theta  = (real'(a) + 0.5) * PI / (2.0 * real'(DEPTH));
      rom[a] = sample_t'($floor(AMPL * $cos(theta) - 0.5));
    end
  end

  // registered read, held while the pipeline is stalled
  always_ff @(posedge clk) begin
    if (advance) begin
      magnitude <= rom[addr];
    end
  end

endmodule

//--- rtl/dds_lane.sv
// ********************
// one cosine lane: quadrant fold, table read, sign restore
// ********************
`timescale 1ns/1ps
`include "dds_cfg.svh"

module dds_lane
  import dds_pkg::*;
(
  input  logic    clk,
  input  logic    reset,
  input  logic    advance,
  input  phase_t  phase,
  output sample_t sample
);

  localparam int P = `DDS_PHASE_BITS;
  localparam int A = `DDS_LUT_ADDR_BITS;

  // top two phase bits select the quadrant
  logic [1:0]   quadrant;
  // phase bits right below the quadrant, truncated to the table width
  logic [A-1:0] fine_addr;
  // table address after the mirror, registered in stage one
  logic [A-1:0] lut_addr;
  // negate flag in stage one and its copy delayed with the table read
  logic         neg_s1;
  logic         neg_s2;
  // table output, always positive
  sample_t      magnitude;

  assign quadrant  = phase[P-1 -: 2];
  assign fine_addr = phase[P-3 -: A];

  // stage one
  // the second and fourth quadrants run the table backwards
  // the lower phase bits below the table width are simply dropped
  always_ff @(posedge clk) begin
    if (advance) begin
      lut_addr <= quadrant[0] ? ~fine_addr : fine_addr;
    end
  end

  // cosine is negative in the second and third quadrants
  // the flag follows the address into stage one and the read into stage two
  always_ff @(posedge clk) begin
    if (reset) begin
      neg_s1 <= 1'b0;
      neg_s2 <= 1'b0;
    end else if (advance) begin
      neg_s1 <= quadrant[1] ^ quadrant[0];
      neg_s2 <= neg_s1;
    end
  end

  // stage two is the registered table read
  dds_quarter_lut lut_i (
    .clk,
    .advance,
    .addr      (lut_addr),
    .magnitude (magnitude)
  );

  // restore the sign, the output register in dds_out_stage captures it
  // magnitude stays below full scale, so the negation cannot overflow
  assign sample = neg_s2 ? -magnitude : magnitude;

endmodule

//--- rtl/dds_out_stage.sv
// ********************
// output register, stage valid tracking, pipeline advance
// ********************
`timescale 1ns/1ps
`include "dds_cfg.svh"

module dds_out_stage
  import dds_pkg::*;
(
  input  logic      clk,
  input  logic      reset,
  input  cos_beat_t samples,
  input  logic      cos_ready,
  output logic      advance,
  output logic      cos_valid,
  output cos_beat_t cos_data
);

  localparam int D = `DDS_PIPE_DEPTH;

  // one valid bit per pipeline stage, bit 0 is the phase register and
  // the top bit is the output register
  logic [D-1:0] stage_valid;

  // the whole pipeline moves together, so it may step whenever the output
  // register is empty or its beat is taken on this edge
  // this is the only place where back-pressure enters the design
  assign advance = ~stage_valid[D-1] | cos_ready;

  // the phase generator always has a word ready, so a one shifts in at the
  // bottom on each advance and the fill after reset is tracked exactly
  always_ff @(posedge clk) begin
    if (reset) begin
      stage_valid <= '0;
    end else if (advance) begin
      stage_valid <= {stage_valid[D-2:0], 1'b1};
    end
  end

  // output register
  // with advance low it holds, so data stays stable while valid waits
  always_ff @(posedge clk) begin
    if (advance) begin
      cos_data <= samples;
    end
  end

  assign cos_valid = stage_valid[D-1];

endmodule

//--- rtl/dds.sv
// ********************
// parallel DDS top: phase generator, cosine lanes, output stage
// ********************
`timescale 1ns/1ps
`include "dds_cfg.svh"

module dds
  import dds_pkg::*;
(
  input  logic      clk,
  input  logic      reset,
  input  logic      phase_inc_valid,
  input  phase_t    phase_inc,
  output logic      cos_valid,
  input  logic      cos_ready,
  output cos_beat_t cos_data
);

  // shared enable of every pipeline register
  logic         advance;
  // one phase per lane from the phase register
  lane_phases_t lane_phases;
  // lane outputs gathered into one beat ahead of the output register
  cos_beat_t    samples;

  dds_phase_gen phase_gen_i (
    .clk,
    .reset,
    .advance,
    .phase_inc_valid,
    .phase_inc,
    .lane_phases
  );

  // identical lanes, lane k turns element k of the phase word into sample k
  for (genvar k = 0; k < `DDS_LANES; k++) begin : lane_gen
    dds_lane lane_i (
      .clk,
      .reset,
      .advance,
      .phase  (lane_phases.phase[k]),
      .sample (samples.sample[k])
    );
  end

  // drains the lanes into the valid/ready stream and drives advance
  dds_out_stage out_stage_i (
    .clk,
    .reset,
    .samples,
    .cos_ready,
    .advance,
    .cos_valid,
    .cos_data
  );

endmodule

//--- sim/dds_chk.sv
// ********************
// stream handshake assertions for dds, bound from the testbench
// ********************
`timescale 1ns/1ps

module dds_chk
  import dds_pkg::*;
(
  input logic      clk,
  input logic      reset,
  input logic      cos_valid,
  input logic      cos_ready,
  input cos_beat_t cos_data
);

  // number of assertion failures so far, the testbench adds it to its own count
  int unsigned fails = 0;

  // a stalled beat must stay on the bus unchanged until it is taken
  hold_while_stalled: assert property (@(posedge clk) disable iff (reset)
    cos_valid && !cos_ready |=> cos_valid && $stable(cos_data))
  else begin
    $error("cos_valid or cos_data changed while the beat was stalled");
    fails++;
  end

  // the output register is empty right after a reset edge
  valid_low_after_reset: assert property (@(posedge clk)
    reset |=> !cos_valid)
  else begin
    $error("cos_valid high in the cycle after reset");
    fails++;
  end

  // every beat offered downstream carries fully known samples
  data_known_when_valid: assert property (@(posedge clk) disable iff (reset)
    cos_valid |-> !$isunknown(cos_data))
  else begin
    $error("cos_data holds unknown bits while cos_valid is high");
    fails++;
  end

endmodule

//--- sim/dds_tb.sv
// ********************
// directed tests and golden cosine model for the parallel DDS
// ********************
`timescale 1ns/1ps
`include "dds_cfg.svh"

module dds_tb
  import dds_pkg::*;
();

  localparam real PI    = 3.14159265358979;
  localparam real AMPL  = (2.0 ** (`DDS_SAMPLE_BITS - 1)) - 0.5;
  // phase bits below the table address and the two quadrant bits
  localparam int  SHIFT = `DDS_PHASE_BITS - `DDS_LUT_ADDR_BITS - 2;
  localparam int  TOL   = 16;

  logic      clk;
  logic      reset;
  logic      phase_inc_valid;
  phase_t    phase_inc;
  logic      cos_valid;
  logic      cos_ready;
  cos_beat_t cos_data;

  // golden model state, model_phase is the lane 0 phase of the next beat
  phase_t    model_phase;
  phase_t    model_inc;
  phase_t    next_inc;
  // beats still due on the old increment after a load
  int        old_beats;
  int        beats;
  int        errors;
  int        test_errors;
  int        tests_run;
  int        tests_failed;

  dds dds_i (
    .clk,
    .reset,
    .phase_inc_valid,
    .phase_inc,
    .cos_valid,
    .cos_ready,
    .cos_data
  );

  bind dds dds_chk chk_i (.*);

  always #2 clk = ~clk;

  // the lanes resolve a phase to one table step, the model takes the
  // centre of that step and applies the table formula with the true sign
  function automatic int expected_sample(input phase_t ph);
    int  step;
    real theta;
    step  = int'(ph >> SHIFT);
    theta = 2.0 * PI * (real'(step) + 0.5) / real'(4 * `DDS_LUT_DEPTH);
    return int'($floor(AMPL * $cos(theta) - 0.5));
  endfunction

  task automatic note_error();
    errors++;
    test_errors++;
  endtask

  task automatic start_test();
    test_errors = 0;
    beats       = 0;
  endtask

  task automatic finish_test(input string name);
    tests_run++;
    if (test_errors != 0) begin
      tests_failed++;
    end
    $display("test %s done, %0d errors", name, test_errors);
  endtask

  // compares one accepted beat with the model and steps the model on
  task automatic check_beat();
    phase_t ph;
    int     exp_val;
    int     got;
    int     diff;
    for (int k = 0; k < `DDS_LANES; k++) begin
      ph      = model_phase + phase_t'(model_inc * k);
      exp_val = expected_sample(ph);
      got     = cos_data.sample[k];
      diff    = (got > exp_val) ? got - exp_val : exp_val - got;
      if (diff > TOL) begin
        $display("error: cos_data lane %0d expected %h got %h",
                 k, sample_t'(exp_val), cos_data.sample[k]);
        note_error();
      end
    end
    model_phase = model_phase + phase_t'(model_inc * `DDS_LANES);
    // the new increment takes over at a beat boundary
    if (old_beats > 0) begin
      old_beats--;
      if (old_beats == 0) begin
        model_inc = next_inc;
      end
    end
    beats++;
  endtask

  // one falling edge, a beat seen now with ready high transfers on the next rise
  task automatic cycle(input logic ready_val);
    @(negedge clk);
    phase_inc_valid = 1'b0;
    cos_ready       = ready_val;
    if (cos_valid && ready_val) begin
      check_beat();
    end
  endtask

  // strobes a new increment, the full pipeline still holds the old one
  task automatic load_inc(input phase_t value, input logic ready_val);
    @(negedge clk);
    cos_ready       = ready_val;
    phase_inc       = value;
    phase_inc_valid = 1'b1;
    if (cos_valid && ready_val) begin
      check_beat();
    end
    next_inc  = value;
    old_beats = `DDS_PIPE_DEPTH;
  endtask

  task automatic drain(input int count, input int max_cycles);
    int n;
    n = 0;
    while (beats < count && n < max_cycles) begin
      cycle(1'b1);
      n++;
    end
    if (beats < count) begin
      $display("timeout: only %0d of %0d beats arrived in %0d cycles", beats, count, n);
      note_error();
    end
  endtask

  task automatic check_valid_low();
    if (cos_valid !== 1'b0) begin
      $display("error: cos_valid expected %h got %h", 1'b0, cos_valid);
      note_error();
    end
  endtask

  task automatic reset_and_first_beat();
    int n;
    start_test();
    // the increment loads while reset is still high
    @(negedge clk);
    phase_inc       = 24'h00_9a3c;
    phase_inc_valid = 1'b1;
    cos_ready       = 1'b1;
    check_valid_low();
    @(negedge clk);
    phase_inc_valid = 1'b0;
    reset           = 1'b0;
    check_valid_low();
    model_phase = '0;
    model_inc   = 24'h00_9a3c;
    old_beats   = 0;
    n = 0;
    while (beats == 0 && n < 20) begin
      cycle(1'b1);
      n++;
    end
    if (beats == 0) begin
      $display("timeout: cos_valid never rose after reset");
      note_error();
    end else if (n != `DDS_PIPE_DEPTH) begin
      $display("first beat came %0d cycles after reset instead of %0d", n, `DDS_PIPE_DEPTH);
      note_error();
    end
    finish_test("reset and first beat");
  endtask

  task automatic steady_frequencies();
    phase_t incs [4] = '{24'h00_0400, 24'h01_2345, 24'h1a_2b3c, 24'h7f_e9a1};
    start_test();
    // the last increment sits just below Nyquist
    for (int i = 0; i < 4; i++) begin
      beats = 0;
      load_inc(incs[i], 1'b1);
      drain(400, 600);
    end
    finish_test("steady frequencies");
  endtask

  task automatic random_backpressure();
    start_test();
    load_inc(24'h02_3456, 1'b1);
    for (int i = 0; i < 300; i++) begin
      cycle(1'($urandom % 2));
    end
    if (beats == 0) begin
      $display("no beat was accepted under random ready");
      note_error();
    end
    finish_test("random backpressure");
  endtask

  task automatic stalled_inc_change();
    int n;
    start_test();
    for (int i = 0; i < 3; i++) begin
      cycle(1'b0);
    end
    n = 0;
    while (!cos_valid && n < 20) begin
      cycle(1'b0);
      n++;
    end
    if (!cos_valid) begin
      $display("timeout: pipeline did not fill while ready was low");
      note_error();
    end
    load_inc(24'h05_0f0f, 1'b0);
    cycle(1'b0);
    drain(40, 100);
    finish_test("increment change while stalled");
  endtask

  task automatic wrap_and_quadrants();
    start_test();
    // just under a quarter turn per sample, so each beat visits every quadrant
    load_inc(24'h3f_f9c3, 1'b1);
    drain(200, 300);
    finish_test("wraparound and quadrants");
  endtask

  initial begin
    clk             = 1'b0;
    reset           = 1'b1;
    phase_inc_valid = 1'b0;
    phase_inc       = '0;
    cos_ready       = 1'b0;
    model_phase     = '0;
    model_inc       = '0;
    next_inc        = '0;
    old_beats       = 0;
    beats           = 0;
    errors          = 0;
    test_errors     = 0;
    tests_run       = 0;
    tests_failed    = 0;
    void'($urandom(32'hacda39eb));
    reset_and_first_beat();
    steady_frequencies();
    random_backpressure();
    stalled_inc_change();
    wrap_and_quadrants();
    $display("%0d tests run, %0d with errors, %0d errors, %0d assertion failures",
             tests_run, tests_failed, errors, dds_i.chk_i.fails);
    if (errors == 0 && dds_i.chk_i.fails == 0) begin
      $display("all tests passed");
    end else begin
      $display("tests failed");
    end
    $finish;
  end

endmodule

//--- dds.f
+incdir+rtl
rtl/dds_pkg.sv
rtl/dds_phase_gen.sv
rtl/dds_quarter_lut.sv
rtl/dds_lane.sv
rtl/dds_out_stage.sv
rtl/dds.sv
sim/dds_chk.sv
sim/dds_tb.sv
